//--- tb.f
+incdir+source
source/noc_pkg.sv
source/noc_input_fifo.sv
source/noc_router_lookup.sv
source/noc_router_lookup_slice.sv
source/noc_route_stage.sv
test/noc_route_stage_chk.sv
test/noc_route_stage_tb.sv

//--- Makefile
# Verilator build and run of the routing stage testbench
# Any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= noc_route_stage_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=
PASS_MSG  ?= Simulation PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass line found in $(LOG)"; \
	else \
		echo "Result: pass line missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/noc_route_stage_tb.sv
/*
 * Testbench for the routing stage
 * Random packets and back-pressure, reference model with per-output queues
 * Watchdog and closing result line
 */

`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_route_stage_tb;

   import noc_pkg::*;

   localparam int CLK_NS     = 8;
   localparam int RST_CYCLES = 8;
   localparam int NUM_PKTS   = 300;
   localparam int MAX_LEN    = 6;
   localparam int OUTS       = `NOC_OUTPUTS;
   localparam int DEST_W     = `NOC_DEST_WIDTH;
   localparam int PAY_W      = `NOC_FLIT_WIDTH - 2 * `NOC_DEST_WIDTH;
   localparam logic [`NOC_DESTS*`NOC_OUTPUTS-1:0] ROUTES = `NOC_ROUTES;
   // Longest packets at one flit per 8 cycles plus a margin
   localparam int TIMEOUT_NS = NUM_PKTS * MAX_LEN * 8 * CLK_NS + 10000;

   // One expected flit in a model queue
   typedef struct packed {
      logic [15:0]                pkt;
      logic                       single;
      logic                       last;
      logic [`NOC_FLIT_WIDTH-1:0] flit;
   } exp_t;

   logic            clk;
   logic            rst;
   flit_t           in_flit;
   logic            in_last;
   logic            in_valid;
   logic            in_ready;
   flit_t           out_flit;
   logic            out_last;
   logic [OUTS-1:0] out_valid;
   logic [OUTS-1:0] out_ready;

   // Model state
   exp_t exp_q [OUTS][$];
   int   order_q [$];
   logic mdl_hdr   = 1'b1;
   int   mdl_out   = 0;
   int   mdl_pkt   = 0;
   int   cur_pkt   = 0;

   // Output of the worm open on the output side or -1 when none is open
   int          worm_out = -1;
   logic [15:0] worm_pkt = '0;

   int sent_flits  = 0;
   int recv_flits  = 0;
   int single_seen = 0;

   int err_route  = 0;
   int err_worm   = 0;
   int err_data   = 0;
   int err_single = 0;
   int err_drain  = 0;
   int err_reset  = 0;

   noc_route_stage DUT (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_last   (in_last),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   // Output index of a destination taken from the one-hot group in the table
   function automatic int route_of(input logic [DEST_W-1:0] dest);
      logic [OUTS-1:0] grp;
      int              o;
      grp = ROUTES[dest*OUTS +: OUTS];
      o = 0;
      for (int i = 0; i < OUTS; i++) begin
         if (grp[i]) begin
            o = i;
         end
      end
      return o;
   endfunction

   function automatic int total_errors();
      return err_route + err_worm + err_data + err_single + err_drain + err_reset;
   endfunction

   task automatic print_counts();
      $display("Errors: route %0d, worm %0d, data %0d, single %0d, drain %0d, reset %0d, total %0d",
               err_route, err_worm, err_data, err_single, err_drain, err_reset,
               total_errors());
   endtask

   // Accepted input flit goes to the queue of its worm's output
   task automatic record_input();
      exp_t e;
      if (mdl_hdr) begin
         mdl_out = route_of(in_flit.header.dest);
         cur_pkt = mdl_pkt;
         mdl_pkt++;
      end
      e.pkt    = 16'(cur_pkt);
      e.single = mdl_hdr & in_last;
      e.last   = in_last;
      e.flit   = in_flit.raw;
      exp_q[mdl_out].push_back(e);
      order_q.push_back(mdl_out);
      // Flit after a last is the next header
      mdl_hdr = in_last;
   endtask

   // Output transfer on o against the model
   task automatic check_output(input int o);
      exp_t e;
      int   exp_out;
      recv_flits++;
      assert (order_q.size() != 0) else begin
         err_data++;
         $display("Output %0d delivered a flit although none was pending", o);
      end
      if (order_q.size() == 0) begin
         return;
      end
      exp_out = order_q.pop_front();
      assert (o == exp_out) else begin
         err_route++;
         $display("error route: expected output %0d, actual output %0d", exp_out, o);
      end
      assert (exp_q[o].size() != 0) else begin
         err_data++;
         $display("Output %0d delivered a flit that its queue does not hold", o);
      end
      if (exp_q[o].size() == 0) begin
         return;
      end
      e = exp_q[o].pop_front();
      assert (out_flit.raw == e.flit && out_last == e.last) else begin
         err_data++;
         $display("error data: expected flit %h last %b, actual flit %h last %b",
                  e.flit, e.last, out_flit.raw, out_last);
      end
      // No other worm may cut in before the open one ends
      if (worm_out >= 0) begin
         assert (o == worm_out && e.pkt == worm_pkt) else begin
            err_worm++;
            $display("error worm: expected output %0d packet %0d, actual output %0d packet %0d",
                     worm_out, worm_pkt, o, e.pkt);
         end
      end
      if (e.single) begin
         single_seen++;
         assert (o == exp_out && out_last) else begin
            err_single++;
            $display("error single: expected output %0d last 1, actual output %0d last %b",
                     exp_out, o, out_last);
         end
      end
      if (out_last) begin
         worm_out = -1;
      end else if (worm_out < 0) begin
         worm_out = o;
         worm_pkt = e.pkt;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // Each output ready high about 70 percent of the cycles
   initial begin
      out_ready = '0;
      forever begin
         @(negedge clk);
         for (int i = 0; i < OUTS; i++) begin
            out_ready[i] = ($urandom_range(9, 0) < 7);
         end
      end
   end

   // Sampled at the rising edge before the DUT flops update
   always @(posedge clk) begin
      if (rst === 1'b0) begin
         for (int i = 0; i < OUTS; i++) begin
            if (out_valid[i] && out_ready[i]) begin
               check_output(i);
            end
         end
         if (in_valid && in_ready) begin
            record_input();
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog: the run did not end within %0d ns and timed out", TIMEOUT_NS);
      print_counts();
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      int    len;
      int    gap;
      flit_t f;
      void'($urandom(32'h2bc911af));
      rst      = 1'b1;
      in_flit  = '0;
      in_last  = 1'b0;
      in_valid = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // First cycle out of reset
      @(posedge clk);
      assert (out_valid == '0 && in_ready) else begin
         err_reset++;
         $display("error reset: expected out_valid 0 in_ready 1, actual out_valid %b in_ready %b",
                  out_valid, in_ready);
      end
      for (int p = 0; p < NUM_PKTS; p++) begin
         len = $urandom_range(MAX_LEN, 1);
         for (int k = 0; k < len; k++) begin
            // Idle gap before about half of the flits
            gap = ($urandom_range(1, 0) == 0) ? 0 : $urandom_range(3, 1);
            repeat (gap) begin
               @(negedge clk);
               in_valid = 1'b0;
            end
            @(negedge clk);
            if (k == 0) begin
               f.header.dest    = DEST_W'($urandom_range(`NOC_DESTS - 1, 0));
               f.header.src     = DEST_W'(p % 8);
               f.header.payload = PAY_W'($urandom());
            end else begin
               f.raw = $urandom();
            end
            in_flit  = f;
            in_last  = (k == len - 1);
            in_valid = 1'b1;
            sent_flits++;
            // Hold until the FIFO takes it
            @(posedge clk);
            while (!in_ready) begin
               @(posedge clk);
            end
         end
      end
      @(negedge clk);
      in_valid = 1'b0;
      in_last  = 1'b0;
      while (recv_flits < sent_flits) begin
         @(posedge clk);
      end
      // A few idle cycles to catch stray output flits
      repeat (10) @(posedge clk);
      for (int i = 0; i < OUTS; i++) begin
         assert (exp_q[i].size() == 0) else begin
            err_drain++;
            $display("error drain: output %0d expected 0 queued flits, actual %0d",
                     i, exp_q[i].size());
         end
      end
      assert (recv_flits == sent_flits && mdl_pkt == NUM_PKTS) else begin
         err_drain++;
         $display("error drain: expected %0d flits of %0d packets, actual %0d flits of %0d",
                  sent_flits, NUM_PKTS, recv_flits, mdl_pkt);
      end
      // Random lengths must have produced single-flit packets at the outputs
      assert (single_seen > 0) else begin
         err_single++;
         $display("error single: expected at least 1 single-flit packet, actual %0d",
                  single_seen);
      end
      print_counts();
      if (total_errors() == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/noc_route_stage_chk.sv
/*
 * Output-side assertions of the routing stage
 * Bound to the top level
 */

`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_route_stage_chk (
   input wire                     clk,
   input wire                     rst,
   input wire noc_pkg::flit_t     out_flit,
   input wire                     out_last,
   input wire [`NOC_OUTPUTS-1:0]  out_valid,
   input wire [`NOC_OUTPUTS-1:0]  out_ready
);

   // Held flit waiting on its own output
   logic stalled;

   assign stalled = |(out_valid & ~out_ready);

   // At most one output offered at a time
   a_one_hot : assert property (@(posedge clk) disable iff (rst)
      $onehot0(out_valid))
      else $error("out_valid %b has more than one bit set", out_valid);

   // Back-pressure freezes flit, last and valid
   a_hold : assert property (@(posedge clk) disable iff (rst)
      stalled |=> ($stable(out_flit) && $stable(out_last) && $stable(out_valid)))
      else $error("Output changed while the selected ready was low");

   // Nothing offered right after a reset cycle
   a_reset : assert property (@(posedge clk)
      rst |=> (out_valid == '0))
      else $error("out_valid %b is not zero after reset", out_valid);

endmodule

bind noc_route_stage noc_route_stage_chk u_chk (
   .clk       (clk),
   .rst       (rst),
   .out_flit  (out_flit),
   .out_last  (out_last),
   .out_valid (out_valid),
   .out_ready (out_ready)
);

`default_nettype wire

//--- source/noc_route_stage.sv
/*
 * Routing stage of one router input port
 * Input FIFO, route lookup and output slice
 */

`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_route_stage (
   input  wire                      clk,
   input  wire                      rst,

   input  wire noc_pkg::flit_t      in_flit,
   input  wire                      in_last,
   input  wire                      in_valid,
   output logic                     in_ready,

   output noc_pkg::flit_t           out_flit,
   output logic                     out_last,
   output logic [`NOC_OUTPUTS-1:0]  out_valid,
   input  wire [`NOC_OUTPUTS-1:0]   out_ready
);

   import noc_pkg::*;

   // FIFO head toward lookup and slice
   flit_t fifo_flit;
   logic  fifo_last;
   logic  fifo_valid;

   // One-hot output select and the slice's ready
   logic [`NOC_OUTPUTS-1:0] sel_valid;
   logic                    slice_ready;

   noc_input_fifo #(
      .DEPTH (`NOC_FIFO_DEPTH)
   ) u_fifo (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_last   (in_last),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (fifo_flit),
      .out_last  (fifo_last),
      .out_valid (fifo_valid),
      .out_ready (slice_ready)
   );

   noc_router_lookup #(
      .FLIT_WIDTH (`NOC_FLIT_WIDTH),
      .DEST_WIDTH (`NOC_DEST_WIDTH),
      .DESTS      (`NOC_DESTS),
      .OUTPUTS    (`NOC_OUTPUTS),
      .ROUTES     (`NOC_ROUTES)
   ) u_lookup (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (fifo_flit),
      .in_last   (fifo_last),
      .in_valid  (fifo_valid),
      .in_ready  (slice_ready),
      .sel_valid (sel_valid)
   );

   // Flit and last bypass the lookup
   noc_router_lookup_slice #(
      .OUTPUTS (`NOC_OUTPUTS)
   ) u_slice (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (fifo_flit),
      .in_last   (fifo_last),
      .in_valid  (sel_valid),
      .in_ready  (slice_ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

`default_nettype wire

//--- source/noc_router_lookup_slice.sv
/*
 * One-entry output register slice
 * Shared flit and last, one-hot valid per output
 */

`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_router_lookup_slice #(
   parameter int OUTPUTS = `NOC_OUTPUTS
) (
   input  wire                 clk,
   input  wire                 rst,

   input  wire noc_pkg::flit_t in_flit,
   input  wire                 in_last,
   input  wire [OUTPUTS-1:0]   in_valid,
   output logic                in_ready,

   output noc_pkg::flit_t      out_flit,
   output logic                out_last,
   output logic [OUTPUTS-1:0]  out_valid,
   input  wire [OUTPUTS-1:0]   out_ready
);

   import noc_pkg::*;

   // Held entry
   flit_t              flit_q;
   logic               last_q;
   logic [OUTPUTS-1:0] valid_q;

   logic held;
   logic leaving;
   logic load;

   assign held    = |valid_q;
   // Only the selected output's ready releases the entry
   assign leaving = |(valid_q & out_ready);

   // Empty, or emptied this cycle, so full rate is kept
   assign in_ready = !held | leaving;
   assign load     = (|in_valid) & in_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
      end else if (load) begin
         valid_q <= in_valid;
      end else if (leaving) begin
         // Left without a replacement
         valid_q <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         flit_q <= in_flit;
         last_q <= in_last;
      end
   end

   assign out_flit  = flit_q;
   assign out_last  = last_q;
   assign out_valid = valid_q;

endmodule

`default_nettype wire

//--- source/noc_router_lookup.sv
/*
 * Route lookup with worm tracking
 * Header dest selects a one-hot output from the route table
 */

`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_router_lookup #(
   parameter int                         FLIT_WIDTH = `NOC_FLIT_WIDTH,
   parameter int                         DEST_WIDTH = `NOC_DEST_WIDTH,
   parameter int                         DESTS      = `NOC_DESTS,
   parameter int                         OUTPUTS    = `NOC_OUTPUTS,
   parameter logic [DESTS*OUTPUTS-1:0]   ROUTES     = `NOC_ROUTES
) (
   input  wire                 clk,
   input  wire                 rst,

   input  wire noc_pkg::flit_t in_flit,
   input  wire                 in_last,
   input  wire                 in_valid,
   // Ready of the slice, the lookup only observes it
   input  wire                 in_ready,

   output logic [OUTPUTS-1:0]  sel_valid
);

   // Table unpacked per destination
   logic [OUTPUTS-1:0] route_tab [DESTS];

   // Output group of the open worm, zero when idle
   logic [OUTPUTS-1:0] worm;
   logic [OUTPUTS-1:0] nxt_worm;
   logic               worm_open;

   logic [DEST_WIDTH-1:0] dest;
   logic [OUTPUTS-1:0]    route;
   logic                  xfer;

   // Flit type must match the width this lookup was built for
   if (FLIT_WIDTH != $bits(in_flit)) begin : g_width_mismatch
      $error("noc_router_lookup: FLIT_WIDTH differs from flit type width");
   end

   for (genvar d = 0; d < DESTS; d++) begin : g_route_tab
      assign route_tab[d] = ROUTES[d*OUTPUTS +: OUTPUTS];
   end

   assign worm_open = |worm;

   // Dest read through the header view
   assign dest  = in_flit.header.dest;
   assign route = route_tab[dest];
   assign xfer  = in_valid & in_ready;

   always_comb begin
      nxt_worm  = worm;
      sel_valid = '0;

      if (!worm_open) begin
         // Idle, any valid flit is a header
         if (in_valid) begin
            sel_valid = route;
         end
         // Single-flit packets never open a worm
         if (xfer && !in_last) begin
            nxt_worm = route;
         end
      end else begin
         // Body flits follow the stored output
         sel_valid = worm & {OUTPUTS{in_valid}};
         if (xfer && in_last) begin
            nxt_worm = '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         worm <= '0;
      end else begin
         worm <= nxt_worm;
      end
   end

endmodule

`default_nettype wire

//--- source/noc_input_fifo.sv
/*
 * Input FIFO of the routing stage
 * Circular buffer plus a registered head entry
 */

`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_input_fifo #(
   parameter int DEPTH = `NOC_FIFO_DEPTH
) (
   input  wire            clk,
   input  wire            rst,

   input  wire noc_pkg::flit_t in_flit,
   input  wire            in_last,
   input  wire            in_valid,
   output logic           in_ready,

   output noc_pkg::flit_t out_flit,
   output logic           out_last,
   output logic           out_valid,
   input  wire            out_ready
);

   import noc_pkg::*;

   localparam int AW = $clog2(DEPTH);

   // Storage behind the head register
   flit_t mem_flit [DEPTH];
   logic  mem_last [DEPTH];

   // Extra MSB tells full from empty
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;

   logic mem_empty;
   logic mem_full;
   logic push;
   logic head_free;
   logic head_from_mem;
   logic bypass;
   logic mem_write;

   assign mem_empty = (wr_ptr == rd_ptr);
   assign mem_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                      (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   // Only a full buffer stalls the sender
   assign in_ready = !mem_full;
   assign push     = in_valid & in_ready;

   // Head can take a new entry when empty or leaving this cycle
   assign head_free     = !out_valid | out_ready;
   assign head_from_mem = head_free & !mem_empty;

   // Empty buffer and free head, the new flit goes straight to the head
   assign bypass    = head_free & mem_empty & push;
   assign mem_write = push & !bypass;

   always_ff @(posedge clk) begin
      if (mem_write) begin
         mem_flit[wr_ptr[AW-1:0]] <= in_flit;
         mem_last[wr_ptr[AW-1:0]] <= in_last;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (mem_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (head_from_mem) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Head valid, goes low when the head leaves with nothing behind it
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (head_free) begin
         out_valid <= head_from_mem | bypass;
      end
   end

   // Head payload, oldest stored entry wins over the bypass
   always_ff @(posedge clk) begin
      if (head_from_mem) begin
         out_flit <= mem_flit[rd_ptr[AW-1:0]];
         out_last <= mem_last[rd_ptr[AW-1:0]];
      end else if (bypass) begin
         out_flit <= in_flit;
         out_last <= in_last;
      end
   end

endmodule

`default_nettype wire

//--- source/noc_pkg.sv
/*
 * Flit type shared by the routing stage
 * One word seen as raw data or as a header
 */

`default_nettype none

`include "noc_defs.svh"

package noc_pkg;

   // Header fields, most significant first
   typedef struct packed {
      logic [`NOC_DEST_WIDTH-1:0]                     dest;
      logic [`NOC_DEST_WIDTH-1:0]                     src;
      logic [`NOC_FLIT_WIDTH-2*`NOC_DEST_WIDTH-1:0]   payload;
   } hdr_t;

   // Body flits only use the raw view
   // Header flits are decoded through the header view
   typedef union packed {
      logic [`NOC_FLIT_WIDTH-1:0] raw;
      hdr_t                       header;
   } flit_t;

endpackage

`default_nettype wire

//--- source/noc_defs.svh
/*
 * Sizes of the routing stage and the default route table
 */

`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// Flit word and header field widths
`define NOC_FLIT_WIDTH 32
`define NOC_DEST_WIDTH 3

// Destinations in the network and outputs of this router
`define NOC_DESTS   8
`define NOC_OUTPUTS 4

// Input FIFO entries, power of two
`define NOC_FIFO_DEPTH 4

// One 4-bit one-hot group per destination, destination d at bits d*4 +: 4
// Destination d goes to output d mod 4
`define NOC_ROUTES 32'h8421_8421

`endif
